//--- design/wiscPkg.sv
/* WISC core shared definitions
   word types, opcode and function codes, ALU operations, fetch constants */
package wiscPkg;
   typedef logic [15:0] wordT;    // data or address word
   typedef logic [15:0] instrT;   // raw instruction word
   typedef logic [2:0]  regIdxT;  // register index
   typedef logic [4:0]  opcodeT;  // instr[15:11]
   typedef logic [2:0]  aluOpT;

   // opcodes, instr[15:11]
   localparam opcodeT OP_HALT  = 5'b00000;
   localparam opcodeT OP_NOP   = 5'b00001;
   localparam opcodeT OP_J     = 5'b00100;
   localparam opcodeT OP_ADDI  = 5'b01000;
   localparam opcodeT OP_SUBI  = 5'b01001;
   localparam opcodeT OP_XORI  = 5'b01010;
   localparam opcodeT OP_ANDNI = 5'b01011;
   localparam opcodeT OP_BEQZ  = 5'b01100;
   localparam opcodeT OP_BNEZ  = 5'b01101;
   localparam opcodeT OP_ST    = 5'b10000;
   localparam opcodeT OP_LD    = 5'b10001;
   localparam opcodeT OP_LBI   = 5'b11000;
   localparam opcodeT OP_ALUR  = 5'b11011;  // R-format, op in instr[1:0]

   // R-format function field
   localparam logic [1:0] FN_ADD  = 2'b00;
   localparam logic [1:0] FN_SUB  = 2'b01;
   localparam logic [1:0] FN_XOR  = 2'b10;
   localparam logic [1:0] FN_ANDN = 2'b11;

   // alu operations, sub is B minus A
   localparam aluOpT ALU_ADD   = 3'd0;
   localparam aluOpT ALU_SUB   = 3'd1;
   localparam aluOpT ALU_XOR   = 3'd2;
   localparam aluOpT ALU_ANDN  = 3'd3;
   localparam aluOpT ALU_PASSB = 3'd4;   // LBI

   localparam wordT RESET_PC    = 16'h0000;  // first fetch address
   localparam wordT INSTR_BYTES = 16'd2;     // pc step per instruction
endpackage

//--- design/regFile.sv
/* register file
   eight 16-bit registers, two asynchronous reads, one synchronous write */
module regFile (
   input  logic            clk,
   input  logic            reset,
   input  wiscPkg::regIdxT read1Sel,
   input  wiscPkg::regIdxT read2Sel,
   output wiscPkg::wordT   read1Data,
   output wiscPkg::wordT   read2Data,
   input  wiscPkg::regIdxT writeSel,
   input  wiscPkg::wordT   writeData,
   input  logic            writeEn
);
   wiscPkg::wordT regs [8];

   // no bypass, one instruction executes at a time
   assign read1Data = regs[read1Sel];
   assign read2Data = regs[read2Sel];

   always_ff @(posedge clk) begin
      if (reset) begin
         for (int i = 0; i < 8; i++) begin
            regs[i] <= '0;
         end
      end else if (writeEn) begin
         regs[writeSel] <= writeData;
      end
   end

   // destination comes from decode of the buffer head
   assert property (@(posedge clk) disable iff (reset) writeEn |-> !$isunknown(writeSel));
endmodule

//--- design/decode.sv
/* decode stage
   control decoding, immediate extension, operand selection and the register file */
module decode (
   input  logic           clk,
   input  logic           reset,
   input  wiscPkg::instrT instr,
   input  wiscPkg::wordT  wbData,
   input  logic           wbEn,
   output wiscPkg::wordT  inA,
   output wiscPkg::wordT  inB,
   output wiscPkg::wordT  storeData,
   output wiscPkg::wordT  imm8,
   output wiscPkg::wordT  imm11,
   output wiscPkg::aluOpT aluOp,
   output logic           isLoad,
   output logic           isStore,
   output logic           isBranch,
   output logic           branchOnZero,
   output logic           isJump,
   output logic           isHalt,
   output logic           illegal,
   output logic           wbFromMem
);
   wiscPkg::opcodeT opcode;
   wiscPkg::regIdxT writeSel;   // destination register
   wiscPkg::wordT   imm5Sext;
   wiscPkg::wordT   imm5Zext;   // XORI, ANDNI
   wiscPkg::wordT   rtData;
   logic            regWrite;   // instr has a destination

   assign opcode    = instr[15:11];
   assign imm5Sext  = {{11{instr[4]}}, instr[4:0]};
   assign imm5Zext  = {11'b0, instr[4:0]};
   assign imm8      = {{8{instr[7]}}, instr[7:0]};
   assign imm11     = {{5{instr[10]}}, instr[10:0]};
   assign storeData = rtData;   // ST writes Rt

   regFile u_regFile (
      .clk       (clk),
      .reset     (reset),
      .read1Sel  (instr[10:8]),   // Rs
      .read2Sel  (instr[7:5]),    // Rt
      .read1Data (inA),
      .read2Data (rtData),
      .writeSel  (writeSel),
      .writeData (wbData),
      .writeEn   (wbEn & regWrite)
   );

   always_comb begin
      aluOp        = wiscPkg::ALU_ADD;
      inB          = '0;           // zero unless an operand is chosen
      writeSel     = instr[7:5];   // I-format and LD
      regWrite     = 1'b0;
      isLoad       = 1'b0;
      isStore      = 1'b0;
      isBranch     = 1'b0;
      branchOnZero = 1'b0;
      isJump       = 1'b0;
      isHalt       = 1'b0;
      illegal      = 1'b0;
      wbFromMem    = 1'b0;
      case (opcode)
         wiscPkg::OP_ADDI, wiscPkg::OP_SUBI: begin
            aluOp    = (opcode == wiscPkg::OP_SUBI) ? wiscPkg::ALU_SUB : wiscPkg::ALU_ADD;
            inB      = imm5Sext;
            regWrite = 1'b1;
         end
         wiscPkg::OP_XORI, wiscPkg::OP_ANDNI: begin
            aluOp    = (opcode == wiscPkg::OP_XORI) ? wiscPkg::ALU_XOR : wiscPkg::ALU_ANDN;
            inB      = imm5Zext;
            regWrite = 1'b1;
         end
         wiscPkg::OP_ALUR: begin
            inB      = rtData;
            writeSel = instr[4:2];   // Rd
            regWrite = 1'b1;
            case (instr[1:0])
               wiscPkg::FN_ADD:  aluOp = wiscPkg::ALU_ADD;
               wiscPkg::FN_SUB:  aluOp = wiscPkg::ALU_SUB;
               wiscPkg::FN_XOR:  aluOp = wiscPkg::ALU_XOR;
               wiscPkg::FN_ANDN: aluOp = wiscPkg::ALU_ANDN;
            endcase
         end
         wiscPkg::OP_LBI: begin
            aluOp    = wiscPkg::ALU_PASSB;
            inB      = imm8;
            writeSel = instr[10:8];
            regWrite = 1'b1;
         end
         wiscPkg::OP_LD: begin
            inB       = imm5Sext;   // address Rs + imm5
            isLoad    = 1'b1;
            wbFromMem = 1'b1;
            regWrite  = 1'b1;
         end
         wiscPkg::OP_ST: begin
            inB     = imm5Sext;
            isStore = 1'b1;
         end
         wiscPkg::OP_BEQZ: begin
            isBranch     = 1'b1;
            branchOnZero = 1'b1;
         end
         wiscPkg::OP_BNEZ: isBranch = 1'b1;
         wiscPkg::OP_J:    isJump = 1'b1;
         wiscPkg::OP_HALT: isHalt = 1'b1;
         wiscPkg::OP_NOP:  regWrite = 1'b0;   // retires with no effect
         default:          illegal = 1'b1;
      endcase
   end
endmodule

//--- design/execute.sv
/* execute stage
   ALU, branch resolution, writeback select and issue/retire sequencing */
module execute (
   input  logic           clk,
   input  logic           reset,
   input  logic           instrValid,
   input  wiscPkg::wordT  instrPc,
   input  wiscPkg::aluOpT aluOp,
   input  logic           isLoad,
   input  logic           isStore,
   input  logic           isBranch,
   input  logic           branchOnZero,
   input  logic           isJump,
   input  logic           isHalt,
   input  logic           illegal,
   input  logic           wbFromMem,
   input  wiscPkg::wordT  inA,
   input  wiscPkg::wordT  inB,
   input  wiscPkg::wordT  storeData,
   input  wiscPkg::wordT  imm8,
   input  wiscPkg::wordT  imm11,
   output logic           instrTake,
   output logic           redirect,
   output wiscPkg::wordT  redirectPc,
   output logic           memStart,
   output logic           memWrite,
   output wiscPkg::wordT  memAddr,
   output wiscPkg::wordT  memWdata,
   input  logic           memDone,
   input  wiscPkg::wordT  memRdata,
   output wiscPkg::wordT  wbData,
   output logic           wbEn,
   output logic           halted,
   output logic           err
);
   typedef enum logic [1:0] {issue, waitMem, stopped} stateT;

   stateT         state;
   wiscPkg::wordT aluResult;
   wiscPkg::wordT offset;      // imm8 or imm11
   logic          isMem;
   logic          canIssue;
   logic          retireNow;   // single-cycle instruction
   logic          taken;

   assign isMem     = isLoad | isStore;
   assign canIssue  = (state == issue) & instrValid;
   assign retireNow = canIssue & ~isMem & ~isHalt & ~illegal;
   assign taken     = isJump | (isBranch & ((inA == '0) == branchOnZero));   // Rs tested

   always_comb begin
      case (aluOp)
         wiscPkg::ALU_ADD:   aluResult = inA + inB;
         wiscPkg::ALU_SUB:   aluResult = inB - inA;
         wiscPkg::ALU_XOR:   aluResult = inA ^ inB;
         wiscPkg::ALU_ANDN:  aluResult = inA & ~inB;
         wiscPkg::ALU_PASSB: aluResult = inB;
         default:            aluResult = '0;
      endcase
   end

   // targets relative to the next instruction
   assign offset     = isJump ? imm11 : imm8;
   assign redirectPc = instrPc + wiscPkg::INSTR_BYTES + offset;
   assign redirect   = retireNow & taken;

   assign memStart = canIssue & isMem;   // one cycle, state leaves issue
   assign memWrite = isStore;
   assign memAddr  = aluResult;
   assign memWdata = storeData;

   // loads retire when the bus transfer ends
   assign instrTake = retireNow | ((state == waitMem) & memDone);
   assign wbEn      = instrTake;
   assign wbData    = wbFromMem ? memRdata : aluResult;

   always_ff @(posedge clk) begin
      if (reset) begin
         state  <= issue;
         halted <= 1'b0;
         err    <= 1'b0;
      end else begin
         case (state)
            issue: begin
               if (canIssue & (isHalt | illegal)) begin
                  state  <= stopped;
                  halted <= 1'b1;
                  err    <= illegal;
               end else if (memStart) begin
                  state <= waitMem;
               end
            end
            waitMem: if (memDone) state <= issue;
            default: state <= stopped;   // held until reset
         endcase
      end
   end

   // the load/store unit only answers an issued memory instruction
   assert property (@(posedge clk) disable iff (reset) memDone |-> state == waitMem);
endmodule

//--- design/fetchUnit.sv
/* instruction fetch
   pc, prefetching bus reads and a two-entry instruction buffer */
module fetchUnit (
   input  logic           clk,
   input  logic           reset,
   input  logic           redirect,
   input  wiscPkg::wordT  redirectPc,
   input  logic           instrTake,
   input  logic           halted,
   output logic           instrValid,
   output wiscPkg::instrT instr,
   output wiscPkg::wordT  instrPc,
   output logic           fetchReq,
   output wiscPkg::wordT  fetchAddr,
   input  logic           fetchGrant,
   input  logic           fetchDone,
   input  wiscPkg::wordT  fetchRdata
);
   wiscPkg::wordT  fetchPc;      // next address to request
   wiscPkg::wordT  busyPc;       // address of the word on the bus
   logic           inFlight;     // granted, waiting for done
   logic           discard;      // in-flight word is from a flushed path
   logic [1:0]     count;        // valid entries, head is entry 0
   logic [1:0]     pushSlot;
   logic           push;
   wiscPkg::instrT bufWord [2];
   wiscPkg::wordT  bufPc [2];

   // an ungranted request may still drop on halt
   assign fetchReq  = inFlight | (~halted & (count != 2'd2));
   assign fetchAddr = inFlight ? busyPc : fetchPc;

   assign push     = fetchDone & ~discard & ~redirect;
   assign pushSlot = count - {1'b0, instrTake};   // first free entry after pop

   assign instrValid = count != 2'd0;
   assign instr      = bufWord[0];
   assign instrPc    = bufPc[0];

   always_ff @(posedge clk) begin
      if (reset) begin
         fetchPc  <= wiscPkg::RESET_PC;
         inFlight <= 1'b0;
         discard  <= 1'b0;
         count    <= 2'd0;
      end else begin
         inFlight <= (inFlight | fetchGrant) & ~fetchDone;
         if (redirect) begin
            fetchPc <= redirectPc;
         end else if (fetchGrant) begin
            fetchPc <= fetchPc + wiscPkg::INSTR_BYTES;
         end
         // the bus transfer still finishes, its word is dropped
         if (redirect & (inFlight | fetchGrant) & ~fetchDone) begin
            discard <= 1'b1;
         end else if (fetchDone) begin
            discard <= 1'b0;
         end
         if (redirect) begin
            count <= 2'd0;   // flush
         end else begin
            count <= count + {1'b0, push} - {1'b0, instrTake};
         end
      end
   end

   always_ff @(posedge clk) begin
      if (fetchGrant) busyPc <= fetchPc;
      if (instrTake) begin
         bufWord[0] <= bufWord[1];
         bufPc[0]   <= bufPc[1];
      end
      if (push) begin   // overrides the shift when both hit entry 0
         bufWord[pushSlot[0]] <= fetchRdata;
         bufPc[pushSlot[0]]   <= busyPc;
      end
   end
endmodule

//--- design/dataAccess.sv
/* load/store requester
   turns one LD or ST from execute into one bus transfer */
module dataAccess (
   input  logic          clk,
   input  logic          reset,
   input  logic          memStart,
   input  logic          memWrite,
   input  wiscPkg::wordT memAddr,
   input  wiscPkg::wordT memWdata,
   output logic          memDone,
   output wiscPkg::wordT memRdata,
   output logic          dataReq,
   output logic          dataWrite,
   output wiscPkg::wordT dataAddr,
   output wiscPkg::wordT dataWdata,
   input  logic          dataDone,
   input  wiscPkg::wordT dataRdata
);
   logic pending;   // request held until the bus reports done

   assign dataReq  = pending;
   assign memDone  = pending & dataDone;
   assign memRdata = dataRdata;   // sampled by execute on memDone

   always_ff @(posedge clk) begin
      if (reset) begin
         pending <= 1'b0;
      end else if (memStart) begin
         pending <= 1'b1;
      end else if (dataDone) begin
         pending <= 1'b0;
      end
   end

   // fields stay fixed for the whole transfer
   always_ff @(posedge clk) begin
      if (memStart) begin
         dataWrite <= memWrite;
         dataAddr  <= memAddr;
         dataWdata <= memWdata;
      end
   end

   // execute waits for memDone before the next memory instruction
   assert property (@(posedge clk) disable iff (reset) memStart |-> !pending);
endmodule

//--- design/busArbiter.sv
/* bus arbiter
   fixed priority, data over fetch, onto one APB requester port */
module busArbiter (
   input  logic          clk,
   input  logic          reset,
   input  logic          fetchReq,
   input  wiscPkg::wordT fetchAddr,
   output logic          fetchGrant,
   output logic          fetchDone,
   output wiscPkg::wordT fetchRdata,
   input  logic          dataReq,
   input  logic          dataWrite,
   input  wiscPkg::wordT dataAddr,
   input  wiscPkg::wordT dataWdata,
   output logic          dataGrant,
   output logic          dataDone,
   output wiscPkg::wordT dataRdata,
   output logic          psel,
   output logic          penable,
   output logic          pwrite,
   output wiscPkg::wordT paddr,
   output wiscPkg::wordT pwdata,
   input  wiscPkg::wordT prdata,
   input  logic          pready
);
   typedef enum logic [1:0] {idle, setup, access} stateT;

   stateT state;
   logic  ownerData;   // load/store unit owns the bus
   logic  xferEnd;

   assign dataGrant  = (state == idle) & dataReq;
   assign fetchGrant = (state == idle) & fetchReq & ~dataReq;

   assign psel    = state != idle;
   assign penable = state == access;
   assign paddr   = ownerData ? dataAddr : fetchAddr;
   assign pwrite  = psel & ownerData & dataWrite;
   assign pwdata  = dataWdata;   // fetch never writes

   assign xferEnd    = penable & pready;
   assign fetchDone  = xferEnd & ~ownerData;
   assign dataDone   = xferEnd & ownerData;
   assign fetchRdata = prdata;
   assign dataRdata  = prdata;

   always_ff @(posedge clk) begin
      if (reset) begin
         state     <= idle;
         ownerData <= 1'b0;
      end else begin
         case (state)
            idle: begin
               if (dataGrant | fetchGrant) begin
                  state     <= setup;
                  ownerData <= dataGrant;
               end
            end
            setup:   state <= access;
            access:  if (pready) state <= idle;   // wait states stretch access
            default: state <= idle;
         endcase
      end
   end

   // requesters must hold their fields while the access phase lasts
   assert property (@(posedge clk) disable iff (reset)
      penable |-> $stable(paddr) && $stable(pwrite) && (!pwrite || $stable(pwdata)));
   // the owner keeps its request up until done
   assert property (@(posedge clk) disable iff (reset)
      psel |-> (ownerData ? dataReq : fetchReq));
endmodule

//--- design/wiscCore.sv
/* WISC core top
   fetch, decode, execute and load/store joined onto one APB memory port */
module wiscCore (
   input  logic          clk,
   input  logic          reset,
   output logic          psel,
   output logic          penable,
   output logic          pwrite,
   output wiscPkg::wordT paddr,
   output wiscPkg::wordT pwdata,
   input  wiscPkg::wordT prdata,
   input  logic          pready,
   output logic          halted,
   output logic          err
);
   // fetch and execute
   logic           instrValid;
   wiscPkg::instrT instr;
   wiscPkg::wordT  instrPc;
   logic           instrTake;
   logic           redirect;
   wiscPkg::wordT  redirectPc;
   // decode outputs
   wiscPkg::wordT  inA;
   wiscPkg::wordT  inB;
   wiscPkg::wordT  storeData;
   wiscPkg::wordT  imm8;
   wiscPkg::wordT  imm11;
   wiscPkg::aluOpT aluOp;
   logic           isLoad;
   logic           isStore;
   logic           isBranch;
   logic           branchOnZero;
   logic           isJump;
   logic           isHalt;
   logic           illegal;
   logic           wbFromMem;
   wiscPkg::wordT  wbData;   // writeback into decode
   logic           wbEn;
   // execute and load/store unit
   logic           memStart;
   logic           memWrite;
   wiscPkg::wordT  memAddr;
   wiscPkg::wordT  memWdata;
   logic           memDone;
   wiscPkg::wordT  memRdata;
   // requesters and arbiter
   logic           fetchReq;
   wiscPkg::wordT  fetchAddr;
   logic           fetchGrant;
   logic           fetchDone;
   wiscPkg::wordT  fetchRdata;
   logic           dataReq;
   logic           dataWrite;
   wiscPkg::wordT  dataAddr;
   wiscPkg::wordT  dataWdata;
   logic           dataDone;
   wiscPkg::wordT  dataRdata;

   decode u_decode (.*);

   execute u_execute (.*);

   fetchUnit u_fetchUnit (.*);

   dataAccess u_dataAccess (.*);   // no grant input, req is held until done

   busArbiter u_busArbiter (
      .*,
      .dataGrant ()
   );
endmodule

//--- testbench/tbWiscCore.sv
/* testbench for the WISC core
   runs the program image from the test file on an APB memory model and checks each store */
module tbWiscCore;
   logic          clk;
   logic          reset;
   logic          psel;
   logic          penable;
   logic          pwrite;
   wiscPkg::wordT paddr;
   wiscPkg::wordT pwdata;
   wiscPkg::wordT prdata;
   logic          pready;
   logic          halted;
   logic          err;

   wiscPkg::wordT mem [256];   // word index is byte address bits 8:1
   wiscPkg::wordT expAddr [$];
   wiscPkg::wordT expData [$];
   logic          expErr;      // err wanted at halt as flagged by the last E line
   logic          loaded;
   int            progWords;
   int            storeIdx;    // next expected store
   int            waitLeft;
   int            valueErrors;
   int            otherErrors;

   wiscCore u_wiscCore (.*);

   always #4 clk = ~clk;

   task automatic checkValue(input string name, input logic [15:0] got,
                             input logic [15:0] expected);
      assert (got === expected) else begin
         $display("FAILED %s: got %h expected %h", name, got, expected);
         valueErrors++;
      end
   endtask

   task automatic checkStore(input wiscPkg::wordT addr, input wiscPkg::wordT data);
      assert (storeIdx < expAddr.size()) else begin
         $display("store of %h to address %h was not expected", data, addr);
         otherErrors++;
      end
      if (storeIdx < expAddr.size()) begin
         checkValue("paddr", addr, expAddr[storeIdx]);
         checkValue("pwdata", data, expData[storeIdx]);
      end
      storeIdx++;
   endtask

   // P lines load the image and E lines queue expected stores
   task automatic readTests();
      int          fd;
      int          n;
      int          c;
      byte         tag;
      logic [15:0] a;
      logic [15:0] d;
      logic        f;
      fd = $fopen("testbench/coreTests.txt", "r");
      if (fd == 0) begin
         $display("could not open testbench/coreTests.txt");
         otherErrors++;
         return;
      end
      n = $fscanf(fd, " %c", tag);
      while (n == 1) begin
         if (tag == "P") begin
            n = $fscanf(fd, "%h %h", a, d);
            mem[a[8:1]] = d;
            progWords++;
         end else if (tag == "E") begin
            n = $fscanf(fd, "%h %h %h", a, d, f);
            expAddr.push_back(a);
            expData.push_back(d);
            expErr = f;
         end else begin
            c = $fgetc(fd);   // skip to end of line
            while (c != 10 && c != -1) begin
               c = $fgetc(fd);
            end
         end
         n = $fscanf(fd, " %c", tag);
      end
      $fclose(fd);
   endtask

   // APB memory with 0 to 3 wait states per access
   always @(posedge clk) begin : memModel
      int waits;
      if (reset) begin
         pready   <= 1'b0;
         waitLeft <= 0;
      end else if (psel && !penable) begin
         waits    = $urandom % 4;
         waitLeft <= waits;
         pready   <= (waits == 0);
         prdata   <= mem[paddr[8:1]];   // address already stable in setup
      end else if (psel && penable && !pready) begin
         waitLeft <= waitLeft - 1;
         pready   <= (waitLeft == 1);
      end else if (psel && penable && pready) begin
         pready <= 1'b0;   // transfer ends on this edge
         if (pwrite) begin
            mem[paddr[8:1]] <= pwdata;
            checkStore(paddr, pwdata);
         end
      end
   end

   initial begin : mainFlow
      clk         = 1'b0;
      reset       = 1'b1;
      prdata      = '0;
      pready      = 1'b0;
      loaded      = 1'b0;
      expErr      = 1'b0;
      progWords   = 0;
      storeIdx    = 0;
      valueErrors = 0;
      otherErrors = 0;
      void'($urandom(32'h80ee));
      // unloaded words decode as illegal opcode 11111
      for (int i = 0; i < 256; i++) begin
         mem[i[7:0]] = {8'hF8, i[7:0]};
      end
      readTests();
      loaded = 1'b1;
      repeat (16) @(posedge clk);
      checkValue("psel", 16'(psel), 16'h0);   // bus and status quiet in reset
      checkValue("penable", 16'(penable), 16'h0);
      checkValue("pwrite", 16'(pwrite), 16'h0);
      checkValue("halted", 16'(halted), 16'h0);
      checkValue("err", 16'(err), 16'h0);
      reset <= 1'b0;
      @(posedge clk);
      while (halted !== 1'b1) begin
         @(posedge clk);
      end
      repeat (20) @(posedge clk);   // a stray store after halt would show here
      checkValue("err", 16'(err), 16'(expErr));
      assert (storeIdx == expAddr.size()) else begin
         $display("saw %0d stores but expected %0d", storeIdx, expAddr.size());
         otherErrors++;
      end
      $display("value errors: %0d, other errors: %0d, stores seen: %0d",
               valueErrors, otherErrors, storeIdx);
      if (valueErrors + otherErrors == 0) begin
         $display("Everything OK");
      end else begin
         $display("Something failed");
      end
      $finish;
   end

   // limit scales with the size of the image
   initial begin : watchdog
      wait (loaded === 1'b1);
      repeat (16 + 200 * progWords) @(posedge clk);
      $display("timeout, core did not halt within %0d cycles", 16 + 200 * progWords);
      $display("Something failed");
      $finish;
   end
endmodule

//--- testbench/coreTests.txt
# P <byte address> <word>  program image and data words
# E <store address> <store data> <err at halt>  expected stores in order
P 0000 C770   # lbi r7, 0x70
P 0002 DFFC   # add r7, r7, r7 -> base 0x00e0
P 0004 C185   # lbi r1, 0x85
P 0006 4159   # addi r2, r1, -7
P 0008 4969   # subi r3, r1, 9
P 000A 519F   # xori r4, r1, 0x1f
P 000C 59B5   # andni r5, r1, 0x15
P 000E 8750
P 0010 8772
P 0012 8794
P 0014 87B6
P 0016 C6F3   # lbi r6, 0xf3
P 0018 D9C8   # add r2, r1, r6
P 001A D9CD   # sub r3 = r6 - r1
P 001C D9D2   # xor r4
P 001E D9D7   # andn r5
P 0020 8758
P 0022 877A
P 0024 879C
P 0026 87BE
P 0028 8F4C   # ld r2, [r7+12]
P 002A 8F6E   # ld r3, [r7+14]
P 002C 4241
P 002E 4361
P 0030 8740
P 0032 8762
P 0034 6002   # beqz r0 taken
P 0036 87C4   # skipped
P 0038 6102   # beqz r1 not taken
P 003A 8724
P 003C 6902   # bnez r1 taken
P 003E 87C6   # skipped
P 0040 6802   # bnez r0 not taken
P 0042 8726
P 0044 C503   # lbi r5, 3
P 0046 87A8   # loop, st r5
P 0048 45BF   # addi r5, r5, -1
P 004A 6502   # beqz r5 exits
P 004C 27F8   # j back to 0x46
P 004E F800   # illegal
P 0050 872A   # never reached
P 00EC 1234
P 00EE BEEF
E 00D0 FF7E 1
E 00D2 0084 1
E 00D4 FF9A 1
E 00D6 FF80 1
E 00D8 FF78 1
E 00DA 006E 1
E 00DC 0076 1
E 00DE 0004 1
E 00E0 1235 1
E 00E2 BEF0 1
E 00E4 FF85 1
E 00E6 FF85 1
E 00E8 0003 1
E 00E8 0002 1
E 00E8 0001 1

//--- sources.f
design/wiscPkg.sv
design/regFile.sv
design/decode.sv
design/execute.sv
design/fetchUnit.sv
design/dataAccess.sv
design/busArbiter.sv
design/wiscCore.sv
testbench/tbWiscCore.sv

//--- run.sh
#!/bin/bash
# build and run the WISC core testbench with Verilator
set -e
set -o pipefail
cd "$(dirname "$0")"

verilator --binary --timing --assert -f sources.f --top-module tbWiscCore -o simWiscCore
./obj_dir/simWiscCore | tee sim.log

if grep -q "Something failed" sim.log; then
   echo "simulation reported a failure"
   exit 1
fi
echo "simulation passed"
